// ==== rtl/cp0Pkg.sv ====
//********************
// shared CP0 constants, register addresses and the exception flag type
// referenced by scoped name from the RTL and the testbench
//********************
package cp0Pkg;

    //********************
    // register addresses
    //********************
    localparam logic [4:0] regBadVAddr = 5'd8;
    localparam logic [4:0] regCount    = 5'd9;
    localparam logic [4:0] regCompare  = 5'd11;
    localparam logic [4:0] regStatus   = 5'd12;
    localparam logic [4:0] regCause    = 5'd13;
    localparam logic [4:0] regEpc      = 5'd14;
    localparam logic [4:0] regPrId     = 5'd15;
    localparam logic [4:0] regConfig   = 5'd16;

    //********************
    // ExcCode values
    //********************
    localparam logic [4:0] excInt  = 5'd0;   // interrupt
    localparam logic [4:0] excAdEL = 5'd4;   // address error, load or fetch
    localparam logic [4:0] excAdES = 5'd5;   // address error, store
    localparam logic [4:0] excSys  = 5'd8;   // syscall
    localparam logic [4:0] excBp   = 5'd9;   // breakpoint
    localparam logic [4:0] excRi   = 5'd10;  // reserved instruction
    localparam logic [4:0] excOv   = 5'd12;  // arithmetic overflow

    //********************
    // field positions
    //********************
    localparam int statusIe     = 0;
    localparam int statusExl    = 1;
    localparam int statusIm     = 8;   // IM7..IM0 at 15:8
    localparam int causeIp      = 8;   // IP7..IP0 at 15:8
    localparam int causeExcCode = 2;   // 6:2
    localparam int causeBd      = 31;

    // CU0 only, kernel mode, interrupts off
    localparam logic [31:0] statusReset = 32'h1000_0000;

    // software IP1..IP0 (9:8), WP (22) and IV (23)
    localparam logic [31:0] causeWriteMask = 32'h00C0_0300;

    // general exception entry point
    localparam logic [31:0] excVector = 32'hBFC0_0380;

    // one bit per pipeline exception source, valid for a single cycle
    typedef struct packed {
        logic adel;   // address error on load or fetch
        logic ades;   // address error on store
        logic ri;     // reserved instruction
        logic ov;     // overflow
        logic sys;    // syscall
        logic bp;     // break
        logic eret;   // exception return
    } excFlags_t;

endpackage

// ==== rtl/cp0ExcIf.sv ====
//********************
// one arbitrated exception record, arbiter to CP0 register file
//********************
`timescale 1ns/1ps

interface cp0ExcIf;

    logic        valid;        // record present this cycle
    logic [4:0]  code;         // ExcCode
    logic        isEret;       // return, not an entry
    logic [31:0] pc;           // faulting instruction PC
    logic        inDelaySlot;
    logic [31:0] badVAddr;
    logic        hasBadAddr;   // address error, load BadVAddr

    // combinational, consumed on the next edge
    modport src (
        output valid, code, isEret, pc, inDelaySlot, badVAddr, hasBadAddr
    );

    modport sink (
        input valid, code, isEret, pc, inDelaySlot, badVAddr, hasBadAddr
    );

endinterface

// ==== rtl/excArbiter.sv ====
//********************
// picks one exception out of the pipeline flags and pending interrupts
// order is interrupt, adel, ri, ov, sys, bp, ades, eret
//********************
`timescale 1ns/1ps

module excArbiter (
    input  cp0Pkg::excFlags_t exc_i,
    input  logic [31:0]       pc_i,
    input  logic              inDelaySlot_i,
    input  logic [31:0]       badVAddr_i,
    input  logic [31:0]       status_i,
    input  logic [31:0]       cause_i,
    cp0ExcIf.src              excOut
);

    logic [7:0] ipMasked;
    logic       intEnabled;
    logic       intPending;

    assign ipMasked   = cause_i[cp0Pkg::causeIp +: 8] & status_i[cp0Pkg::statusIm +: 8];
    assign intEnabled = status_i[cp0Pkg::statusIe] & ~status_i[cp0Pkg::statusExl];
    assign intPending = (|ipMasked) & intEnabled;

    // the faulting context passes straight through
    assign excOut.pc          = pc_i;
    assign excOut.inDelaySlot = inDelaySlot_i;
    assign excOut.badVAddr    = badVAddr_i;

    always_comb begin
        excOut.valid      = 1'b0;
        excOut.code       = cp0Pkg::excInt;
        excOut.isEret     = 1'b0;
        excOut.hasBadAddr = 1'b0;

        if (intPending) begin
            excOut.valid = 1'b1;               // code stays excInt
        end else if (exc_i.adel) begin
            excOut.valid      = 1'b1;
            excOut.code       = cp0Pkg::excAdEL;
            excOut.hasBadAddr = 1'b1;
        end else if (exc_i.ri) begin
            excOut.valid = 1'b1;
            excOut.code  = cp0Pkg::excRi;
        end else if (exc_i.ov) begin
            excOut.valid = 1'b1;
            excOut.code  = cp0Pkg::excOv;
        end else if (exc_i.sys) begin
            excOut.valid = 1'b1;
            excOut.code  = cp0Pkg::excSys;
        end else if (exc_i.bp) begin
            excOut.valid = 1'b1;
            excOut.code  = cp0Pkg::excBp;
        end else if (exc_i.ades) begin
            excOut.valid      = 1'b1;
            excOut.code       = cp0Pkg::excAdES;
            excOut.hasBadAddr = 1'b1;
        end else if (exc_i.eret) begin
            excOut.valid  = 1'b1;                // redirect to EPC
            excOut.isEret = 1'b1;
        end
    end

endmodule

// ==== rtl/cp0Timer.sv ====
//********************
// Count and Compare with the sticky timer interrupt
//********************
`timescale 1ns/1ps

module cp0Timer (
    input  logic        clk,
    input  logic        rst,
    input  logic        wrEn_i,
    input  logic [4:0]  wrAddr_i,
    input  logic [31:0] wrData_i,
    output logic [31:0] count_o,
    output logic [31:0] compare_o,
    output logic        timerInt_o
);

    logic wrCount;
    logic wrCompare;
    logic match;

    assign wrCount   = wrEn_i && (wrAddr_i == cp0Pkg::regCount);
    assign wrCompare = wrEn_i && (wrAddr_i == cp0Pkg::regCompare);
    assign match     = (compare_o != 32'd0) && (count_o == compare_o);

    always_ff @(posedge clk) begin
        if (!rst) begin
            count_o    <= 32'd0;
            compare_o  <= 32'd0;
            timerInt_o <= 1'b0;
        end else begin
            // a write to Count wins over the increment
            if (wrCount) begin
                count_o <= wrData_i;
            end else begin
                count_o <= count_o + 32'd1;
            end

            if (match) begin
                timerInt_o <= 1'b1;      // sticky
            end

            // writing Compare acknowledges the interrupt
            if (wrCompare) begin
                compare_o  <= wrData_i;
                timerInt_o <= 1'b0;
            end
        end
    end

    //********************
    // checks
    //********************
    // a rise comes only from a match against a nonzero Compare
    assert property (@(posedge clk) disable iff (!rst)
        $rose(timerInt_o) |-> ($past(compare_o) != 32'd0) && (compare_o != 32'd0))
        else $error("timer interrupt rose while Compare was zero");

endmodule

// ==== rtl/cp0RegFile.sv ====
//********************
// Status, Cause, EPC and BadVAddr with exception entry and return
// also holds the register read mux and drives the pipeline redirect
//********************
`timescale 1ns/1ps

module cp0RegFile #(
    parameter logic [31:0] prIdValue   = 32'h0000_4220,
    parameter logic [31:0] configValue = 32'h0000_8000
) (
    input  logic        clk,
    input  logic        rst,

    // write port, one cycle
    input  logic        wrEn_i,
    input  logic [4:0]  wrAddr_i,
    input  logic [31:0] wrData_i,

    // read port, combinational
    input  logic [4:0]  rdAddr_i,
    output logic [31:0] rdData_o,

    input  logic [5:0]  hwInt_i,
    input  logic [31:0] count_i,
    input  logic [31:0] compare_i,
    input  logic        timerInt_i,

    cp0ExcIf.sink       excIn,

    output logic [31:0] status_o,
    output logic [31:0] cause_o,
    output logic [31:0] epc_o,
    output logic        redirect_o,
    output logic [31:0] redirectPc_o
);

    logic [31:0] statusQ;
    logic [31:0] causeQ;
    logic [31:0] epcQ;
    logic [31:0] badVAddrQ;

    logic        excEntry;
    logic        excReturn;
    logic [31:0] epcNext;
    logic [5:0]  hwIp;

    assign excEntry  = excIn.valid && !excIn.isEret;
    assign excReturn = excIn.valid && excIn.isEret;

    // delay-slot faults restart at the branch
    assign epcNext = excIn.inDelaySlot ? (excIn.pc - 32'd4) : excIn.pc;

    // IP7 is shared with the timer
    assign hwIp = {hwInt_i[5] | timerInt_i, hwInt_i[4:0]};

    //********************
    // register update
    //********************
    always_ff @(posedge clk) begin
        if (!rst) begin
            statusQ   <= cp0Pkg::statusReset;
            causeQ    <= 32'd0;
            epcQ      <= 32'd0;
            badVAddrQ <= 32'd0;
        end else begin
            // software writes first, exception update overrides below
            if (wrEn_i) begin
                case (wrAddr_i)
                    cp0Pkg::regStatus: statusQ <= wrData_i;
                    cp0Pkg::regCause: begin
                        causeQ <= (causeQ & ~cp0Pkg::causeWriteMask)
                                | (wrData_i & cp0Pkg::causeWriteMask);
                    end
                    cp0Pkg::regEpc:    epcQ <= wrData_i;
                    default: ;          // BadVAddr is read-only
                endcase
            end

            // IP7..IP2 sampled every cycle, not writable
            causeQ[cp0Pkg::causeIp + 2 +: 6] <= hwIp;

            if (excEntry) begin
                statusQ[cp0Pkg::statusExl]       <= 1'b1;
                causeQ[cp0Pkg::causeExcCode +: 5] <= excIn.code;
                // nested exception keeps the first EPC and BD
                if (!statusQ[cp0Pkg::statusExl]) begin
                    epcQ                   <= epcNext;
                    causeQ[cp0Pkg::causeBd] <= excIn.inDelaySlot;
                end
                if (excIn.hasBadAddr) begin
                    badVAddrQ <= excIn.badVAddr;
                end
            end else if (excReturn) begin
                statusQ[cp0Pkg::statusExl] <= 1'b0;
            end
        end
    end

    //********************
    // read mux
    //********************
    always_comb begin
        case (rdAddr_i)
            cp0Pkg::regBadVAddr: rdData_o = badVAddrQ;
            cp0Pkg::regCount:    rdData_o = count_i;
            cp0Pkg::regCompare:  rdData_o = compare_i;
            cp0Pkg::regStatus:   rdData_o = statusQ;
            cp0Pkg::regCause:    rdData_o = causeQ;
            cp0Pkg::regEpc:      rdData_o = epcQ;
            cp0Pkg::regPrId:     rdData_o = prIdValue;
            cp0Pkg::regConfig:   rdData_o = configValue;
            default:             rdData_o = 32'd0;   // unimplemented
        endcase
    end

    assign status_o = statusQ;
    assign cause_o  = causeQ;
    assign epc_o    = epcQ;

    // eret goes back to EPC, everything else to the fixed vector
    assign redirect_o   = excIn.valid;
    assign redirectPc_o = excIn.isEret ? epcQ : cp0Pkg::excVector;

    //********************
    // checks
    //********************
    // every redirect leaves EXL set after an entry and clear after an eret
    assert property (@(posedge clk) disable iff (!rst)
        redirect_o |=> (statusQ[cp0Pkg::statusExl] == !$past(excIn.isEret)))
        else $error("EXL does not follow the redirect taken");

endmodule

// ==== rtl/cp0Top.sv ====
//********************
// CP0 top level, arbiter, timer and register file wired together
//********************
`timescale 1ns/1ps

module cp0Top #(
    parameter logic [31:0] prIdValue   = 32'h0000_4220,
    parameter logic [31:0] configValue = 32'h0000_8000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wrEn_i,
    input  logic [4:0]        wrAddr_i,
    input  logic [31:0]       wrData_i,
    input  logic [4:0]        rdAddr_i,
    output logic [31:0]       rdData_o,
    input  cp0Pkg::excFlags_t exc_i,
    input  logic [31:0]       pc_i,
    input  logic              inDelaySlot_i,
    input  logic [31:0]       badVAddr_i,
    input  logic [5:0]        hwInt_i,
    output logic              redirect_o,
    output logic [31:0]       redirectPc_o,
    output logic              timerInt_o,
    output logic [31:0]       status_o,
    output logic [31:0]       cause_o,
    output logic [31:0]       epc_o
);

    logic [31:0] count;
    logic [31:0] compare;

    cp0ExcIf excBus ();

    excArbiter i_arbiter (
        .exc_i         (exc_i),
        .pc_i          (pc_i),
        .inDelaySlot_i (inDelaySlot_i),
        .badVAddr_i    (badVAddr_i),
        .status_i      (status_o),   // registered, no loop
        .cause_i       (cause_o),
        .excOut        (excBus.src)
    );

    cp0Timer i_timer (
        .clk        (clk),
        .rst        (rst),
        .wrEn_i     (wrEn_i),
        .wrAddr_i   (wrAddr_i),
        .wrData_i   (wrData_i),
        .count_o    (count),
        .compare_o  (compare),
        .timerInt_o (timerInt_o)
    );

    cp0RegFile #(
        .prIdValue   (prIdValue),
        .configValue (configValue)
    ) i_regFile (
        .clk          (clk),
        .rst          (rst),
        .wrEn_i       (wrEn_i),
        .wrAddr_i     (wrAddr_i),
        .wrData_i     (wrData_i),
        .rdAddr_i     (rdAddr_i),
        .rdData_o     (rdData_o),
        .hwInt_i      (hwInt_i),
        .count_i      (count),
        .compare_i    (compare),
        .timerInt_i   (timerInt_o),
        .excIn        (excBus.sink),
        .status_o     (status_o),
        .cause_o      (cause_o),
        .epc_o        (epc_o),
        .redirect_o   (redirect_o),
        .redirectPc_o (redirectPc_o)
    );

endmodule

// ==== verif/cp0Tb.sv ====
//********************
// random-stimulus testbench for the CP0 top level
// a cycle model predicts every output and is compared each cycle
//********************
`timescale 1ns/1ps

module cp0Tb;

    localparam logic [31:0] prIdVal = 32'h0001_8001;
    localparam logic [31:0] cfgVal  = 32'h8000_0483;

    logic               clk;
    logic               rst;
    logic               wrEn;
    logic [4:0]         wrAddr;
    logic [31:0]        wrData;
    logic [4:0]         rdAddr;
    logic [31:0]        rdData;
    cp0Pkg::excFlags_t  exc;
    logic [31:0]        pc;
    logic               inDelaySlot;
    logic [31:0]        badVAddr;
    logic [5:0]         hwInt;
    logic               redirect;
    logic [31:0]        redirectPc;
    logic               timerInt;
    logic [31:0]        status;
    logic [31:0]        cause;
    logic [31:0]        epc;

    // model state
    logic [31:0] mCount, mCompare, mStatus, mCause, mEpc, mBad;
    logic        mTimer;
    logic [31:0] lfsr;
    int          errCount;
    int          i;
    int          waitCnt;

    cp0Top #(.prIdValue(prIdVal), .configValue(cfgVal)) i_dut (
        .clk(clk), .rst(rst), .wrEn_i(wrEn), .wrAddr_i(wrAddr), .wrData_i(wrData),
        .rdAddr_i(rdAddr), .rdData_o(rdData), .exc_i(exc), .pc_i(pc),
        .inDelaySlot_i(inDelaySlot), .badVAddr_i(badVAddr), .hwInt_i(hwInt),
        .redirect_o(redirect), .redirectPc_o(redirectPc), .timerInt_o(timerInt),
        .status_o(status), .cause_o(cause), .epc_o(epc)
    );

    always #2 clk = ~clk;   // 4 ns period

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        int          k;
        r = 32'd0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [4:0] pickAddr();
        logic [4:0] table8 [8];
        logic [2:0] idx;
        table8 = '{cp0Pkg::regBadVAddr, cp0Pkg::regCount, cp0Pkg::regCompare,
                   cp0Pkg::regStatus, cp0Pkg::regCause, cp0Pkg::regEpc,
                   cp0Pkg::regPrId, cp0Pkg::regConfig};
        if (randBits(3) == 32'd0) begin
            return 5'(randBits(5));   // maybe unmapped
        end
        idx = 3'(randBits(3));
        return table8[idx];
    endfunction

    function automatic logic [31:0] expRead(input logic [4:0] a);
        case (a)
            cp0Pkg::regBadVAddr: return mBad;
            cp0Pkg::regCount:    return mCount;
            cp0Pkg::regCompare:  return mCompare;
            cp0Pkg::regStatus:   return mStatus;
            cp0Pkg::regCause:    return mCause;
            cp0Pkg::regEpc:      return mEpc;
            cp0Pkg::regPrId:     return prIdVal;
            cp0Pkg::regConfig:   return cfgVal;
            default:             return 32'd0;
        endcase
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic idleInputs();
        wrEn        = 1'b0;
        wrAddr      = 5'd0;
        wrData      = 32'd0;
        exc         = '0;
        hwInt       = 6'd0;
    endtask

    task automatic driveWrite(input logic [4:0] addr, input logic [31:0] data);
        wrEn   = 1'b1;
        wrAddr = addr;
        wrData = data;
    endtask

    //********************
    // check outputs then advance the model by one cycle
    //********************
    task automatic runCycle();
        logic        eValid, eEret, eBad, intPend;
        logic [4:0]  eCode;
        logic [31:0] nCount, nCompare, nStatus, nCause, nEpc, nBad;
        logic        nTimer;
        #1;
        intPend = (|(mCause[15:8] & mStatus[15:8])) && mStatus[0] && !mStatus[1];
        eValid = 1'b1;
        eEret  = 1'b0;
        eCode  = cp0Pkg::excInt;
        if (intPend)       eCode = cp0Pkg::excInt;
        else if (exc.adel) eCode = cp0Pkg::excAdEL;
        else if (exc.ri)   eCode = cp0Pkg::excRi;
        else if (exc.ov)   eCode = cp0Pkg::excOv;
        else if (exc.sys)  eCode = cp0Pkg::excSys;
        else if (exc.bp)   eCode = cp0Pkg::excBp;
        else if (exc.ades) eCode = cp0Pkg::excAdES;
        else if (exc.eret) eEret = 1'b1;
        else               eValid = 1'b0;
        // address errors also load BadVAddr
        eBad = (eCode == cp0Pkg::excAdEL) || (eCode == cp0Pkg::excAdES);

        checkVal("rdData_o", rdData, expRead(rdAddr));
        checkVal("redirect_o", 32'(redirect), 32'(eValid));
        if (eValid) begin
            checkVal("redirectPc_o", redirectPc, eEret ? mEpc : cp0Pkg::excVector);
        end
        checkVal("timerInt_o", 32'(timerInt), 32'(mTimer));
        checkVal("status_o", status, mStatus);
        checkVal("cause_o", cause, mCause);
        checkVal("epc_o", epc, mEpc);

        nCount   = (wrEn && wrAddr == cp0Pkg::regCount) ? wrData : mCount + 32'd1;
        nCompare = mCompare;
        nTimer   = mTimer | ((mCompare != 32'd0) && (mCount == mCompare));
        if (wrEn && wrAddr == cp0Pkg::regCompare) begin
            nCompare = wrData;
            nTimer   = 1'b0;
        end
        nStatus = mStatus;
        nCause  = mCause;
        nEpc    = mEpc;
        nBad    = mBad;
        if (wrEn && wrAddr == cp0Pkg::regStatus) nStatus = wrData;
        if (wrEn && wrAddr == cp0Pkg::regCause)
            nCause = (mCause & ~cp0Pkg::causeWriteMask) | (wrData & cp0Pkg::causeWriteMask);
        if (wrEn && wrAddr == cp0Pkg::regEpc) nEpc = wrData;
        nCause[15:10] = {hwInt[5] | mTimer, hwInt[4:0]};
        if (eValid && !eEret) begin
            nStatus[1]   = 1'b1;
            nCause[6:2]  = eCode;
            if (!mStatus[1]) begin
                nEpc       = inDelaySlot ? pc - 32'd4 : pc;
                nCause[31] = inDelaySlot;
            end
            if (eBad) nBad = badVAddr;
        end else if (eEret) begin
            nStatus[1] = 1'b0;
        end

        @(posedge clk);
        {mCount, mCompare, mTimer} = {nCount, nCompare, nTimer};
        {mStatus, mCause, mEpc, mBad} = {nStatus, nCause, nEpc, nBad};
        #1;
    endtask

    task automatic driveRandom();
        logic [3:0] r;
        wrEn   = (randBits(2) == 32'd0);
        wrAddr = pickAddr();
        wrData = randBits(32);
        rdAddr = pickAddr();
        r = 4'(randBits(4));
        if (r == 4'd0) begin
            exc = cp0Pkg::excFlags_t'(7'(randBits(7)));   // several at once
        end else if (r < 4'd3) begin
            exc = cp0Pkg::excFlags_t'(7'd1 << (randBits(3) % 7));
        end else begin
            exc = '0;
        end
        pc          = randBits(32) & ~32'd3;
        inDelaySlot = 1'(randBits(1));
        badVAddr    = randBits(32);
        if (randBits(3) == 32'd0) hwInt = 6'(randBits(6));
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b0;
        rdAddr      = 5'd0;
        pc          = 32'd0;
        inDelaySlot = 1'b0;
        badVAddr    = 32'd0;
        idleInputs();
        lfsr     = 32'd81;
        errCount = 0;
        mCount   = 32'd0;
        mCompare = 32'd0;
        mTimer   = 1'b0;
        mEpc     = 32'd0;
        mBad     = 32'd0;
        mCause   = 32'd0;
        mStatus  = cp0Pkg::statusReset;
        repeat (16) @(posedge clk);
        #1 rst = 1'b1;

        //********************
        // timer match and acknowledge
        //********************
        driveWrite(cp0Pkg::regCompare, mCount + 32'd6);
        rdAddr = cp0Pkg::regCount;
        runCycle();
        idleInputs();
        waitCnt = 0;
        while (!timerInt && waitCnt < 40) begin
            runCycle();
            waitCnt++;
        end
        if (!timerInt) begin
            errCount++;
            $display("timer interrupt never rose after the Compare match");
        end
        driveWrite(cp0Pkg::regCompare, 32'd0);
        runCycle();
        // Count wraps through zero while Compare is zero
        driveWrite(cp0Pkg::regCount, 32'hFFFF_FFF0);
        runCycle();
        idleInputs();
        for (i = 0; i < 30; i++) runCycle();

        // random mix of writes, reads, exceptions and interrupts
        for (i = 0; i < 4000; i++) begin
            driveRandom();
            runCycle();
        end

        $display("errors: %0d", errCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/cp0Pkg.sv
rtl/cp0ExcIf.sv
rtl/excArbiter.sv
rtl/cp0Timer.sv
rtl/cp0RegFile.sv
rtl/cp0Top.sv
verif/cp0Tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the CP0 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cp0Tb -f sources.f -o cp0Sim

output=$(./obj_dir/cp0Sim || true)
echo "$output"

if echo "$output" | grep -q "TESTS PASSED"; then
    exit 0
else
    exit 1
fi
